// ==== trs_io_pkg.sv ====
`default_nettype none

package trs_io_pkg;

  // basic widths on the command channel
  typedef logic [7:0]  byte_t;
  typedef logic [7:0]  opcode_t;
  // red in the top byte
  typedef logic [23:0] rgb_t;
  typedef logic [1:0]  param_idx_t;

  typedef enum logic {
    idle,
    read_bytes
  } parse_state_t;

  // kept ESP opcodes
  localparam opcode_t op_get_cookie       = 8'd0;
  localparam opcode_t op_get_version      = 8'd15;
  localparam opcode_t op_get_mode         = 8'd16;
  localparam opcode_t op_set_screen_color = 8'd17;
  localparam opcode_t op_set_led          = 8'd26;
  localparam opcode_t op_get_config       = 8'd27;
  localparam opcode_t op_set_spi_ctrl_reg = 8'd29;
  localparam opcode_t op_set_spi_data     = 8'd30;
  localparam opcode_t op_get_spi_data     = 8'd31;

  localparam byte_t      cookie             = 8'hAF;
  localparam logic [2:0] version_major      = 3'd0;
  localparam logic [4:0] version_minor      = 5'd3;
  // PocketTRS Model III
  localparam logic [3:0] base_mode          = 4'b0011;
  localparam rgb_t       screen_color_reset = '1;

  // system clocks per flash bit
  localparam int flash_bit_cycles = 16;
  localparam int max_params       = 3;

  // number of parameter bytes following an opcode
  function automatic param_idx_t param_count(input opcode_t op, output logic known);
    known = 1'b1;
    case (op)
      op_get_cookie, op_get_version, op_get_mode,
      op_get_config, op_get_spi_data:
        param_count = 2'd0;
      op_set_led, op_set_spi_ctrl_reg, op_set_spi_data:
        param_count = 2'd1;
      op_set_screen_color:
        param_count = param_idx_t'(max_params);
      default: begin
        known       = 1'b0;
        param_count = 2'd0;
      end
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== cmd_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// one executed command, parser to executors
interface cmd_if;
  import trs_io_pkg::*;

  logic    exec;
  opcode_t opcode;
  byte_t   param_0;
  byte_t   param_1;
  byte_t   param_2;

  modport source (output exec, output opcode, output param_0, output param_1, output param_2);
  modport sink   (input exec, input opcode, input param_0, input param_1, input param_2);

endinterface

`default_nettype wire

// ==== esp_spi_slave.sv ====
`timescale 1ns/100ps
`default_nettype none

module esp_spi_slave (
  input  logic              clk,
  input  logic              cass_out_sel_n,
  input  logic              spi_cs_n,
  input  logic              sck,
  input  logic              mosi,
  output logic              miso,
  input  trs_io_pkg::byte_t tx_byte,
  output trs_io_pkg::byte_t rx_byte,
  output logic              rx_valid
);
  import trs_io_pkg::*;

  logic [2:0] sck_sync;
  logic [1:0] cs_sync;
  logic [1:0] mosi_sync;
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_active;
  logic [2:0] bit_cnt;
  byte_t      tx_shift;

  // two flops for metastability, third one for edge detect on sck
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      sck_sync  <= 3'b000;
      cs_sync   <= 2'b11;
      mosi_sync <= 2'b00;
    end else begin
      sck_sync  <= {sck_sync[1:0], sck};
      cs_sync   <= {cs_sync[0], spi_cs_n};
      mosi_sync <= {mosi_sync[0], mosi};
    end
  end

  assign sck_rise  = (sck_sync[2:1] == 2'b01);
  assign sck_fall  = (sck_sync[2:1] == 2'b10);
  assign cs_active = ~cs_sync[1];

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      bit_cnt  <= 3'd0;
      rx_valid <= 1'b0;
      tx_shift <= '0;
    end else begin
      rx_valid <= 1'b0;
      if (!cs_active) begin
        bit_cnt <= 3'd0;
      end else begin
        if (sck_rise) begin
          bit_cnt <= bit_cnt + 3'd1;
          // eighth bit completes the byte
          if (bit_cnt == 3'd7) begin
            rx_valid <= 1'b1;
          end
        end
        if (sck_fall) begin
          // pending response is picked up after the first bit
          if (bit_cnt == 3'd1) begin
            tx_shift <= tx_byte;
          end else begin
            tx_shift <= {tx_shift[6:0], 1'b0};
          end
        end
      end
    end
  end

  // msb first receive shifter
  always_ff @(posedge clk) begin
    if (cs_active && sck_rise) begin
      rx_byte <= {rx_byte[6:0], mosi_sync[1]};
    end
  end

  // single slave on the link, so no tri-state
  assign miso = cs_active & tx_shift[7];

endmodule

`default_nettype wire

// ==== cmd_parser.sv ====
`timescale 1ns/100ps
`default_nettype none

module cmd_parser (
  input  logic              clk,
  input  logic              cass_out_sel_n,
  input  trs_io_pkg::byte_t rx_byte,
  input  logic              rx_valid,
  cmd_if.source             cmd,
  output logic              unknown_op
);
  import trs_io_pkg::*;

  parse_state_t state;
  param_idx_t   idx;
  param_idx_t   need;
  param_idx_t   lookup_cnt;
  logic         lookup_known;
  logic         exec_q;
  opcode_t      opcode_q;
  byte_t        param_buf [max_params];

  // opcode lookup on the incoming byte
  always_comb begin
    lookup_cnt = param_count(rx_byte, lookup_known);
  end

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      state      <= idle;
      idx        <= 2'd0;
      need       <= 2'd0;
      exec_q     <= 1'b0;
      unknown_op <= 1'b0;
    end else begin
      exec_q     <= 1'b0;
      unknown_op <= 1'b0;
      if (rx_valid) begin
        case (state)
          idle: begin
            idx  <= 2'd0;
            need <= lookup_cnt;
            if (!lookup_known) begin
              // stay idle, just flag it
              unknown_op <= 1'b1;
            end else if (lookup_cnt == 2'd0) begin
              exec_q <= 1'b1;
            end else begin
              state <= read_bytes;
            end
          end
          read_bytes: begin
            idx <= idx + 2'd1;
            if (idx == need - 2'd1) begin
              exec_q <= 1'b1;
              state  <= idle;
            end
          end
          default: begin
            state <= idle;
          end
        endcase
      end
    end
  end

  // opcode and parameter storage
  always_ff @(posedge clk) begin
    if (rx_valid) begin
      if (state == idle && lookup_known) begin
        opcode_q <= rx_byte;
      end
      if (state == read_bytes) begin
        param_buf[idx] <= rx_byte;
      end
    end
  end

  assign cmd.exec    = exec_q;
  assign cmd.opcode  = opcode_q;
  assign cmd.param_0 = param_buf[0];
  assign cmd.param_1 = param_buf[1];
  assign cmd.param_2 = param_buf[2];

endmodule

`default_nettype wire

// ==== cmd_exec.sv ====
`timescale 1ns/100ps
`default_nettype none

module cmd_exec (
  input  logic              clk,
  input  logic              cass_out_sel_n,
  cmd_if.sink               cmd,
  input  logic              unknown_op,
  input  logic [3:0]        conf,
  input  trs_io_pkg::byte_t flash_data,
  output trs_io_pkg::byte_t tx_byte,
  output logic              led_red,
  output logic              led_green,
  output logic              led_blue,
  output logic              error_led,
  output trs_io_pkg::rgb_t  screen_color
);
  import trs_io_pkg::*;

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      led_red      <= 1'b0;
      led_green    <= 1'b0;
      led_blue     <= 1'b0;
      error_led    <= 1'b0;
      screen_color <= screen_color_reset;
      tx_byte      <= '0;
    end else begin
      // sticky until reset
      if (unknown_op) begin
        error_led <= 1'b1;
      end
      if (cmd.exec) begin
        case (cmd.opcode)
          op_set_led: begin
            led_red   <= cmd.param_0[0];
            led_green <= cmd.param_0[1];
            led_blue  <= cmd.param_0[2];
          end
          op_set_screen_color: begin
            screen_color <= {cmd.param_0, cmd.param_1, cmd.param_2};
          end
          op_get_cookie: begin
            tx_byte <= cookie;
          end
          op_get_version: begin
            tx_byte <= {version_major, version_minor};
          end
          op_get_mode: begin
            // dip 4 off selects the alternate mode bit
            tx_byte <= {4'b0000, base_mode | {~conf[3], 3'b000}};
          end
          op_get_config: begin
            // video mode bits read as zero here
            tx_byte <= {4'b0000, ~conf};
          end
          op_get_spi_data: begin
            tx_byte <= flash_data;
          end
          default: begin
            tx_byte <= tx_byte;
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== flash_spi_master.sv ====
`timescale 1ns/100ps
`default_nettype none

module flash_spi_master (
  input  logic              clk,
  input  logic              cass_out_sel_n,
  cmd_if.sink               cmd,
  input  logic              flash_spi_so,
  output trs_io_pkg::byte_t flash_data,
  output logic              flash_spi_cs_n,
  output logic              flash_spi_clk,
  output logic              flash_spi_si
);
  import trs_io_pkg::*;

  logic                                   spi_cs;
  logic                                   busy;
  logic [$clog2(8 * flash_bit_cycles)-1:0] bit_timer;
  byte_t                                  shift_reg;
  logic                                   start;

  // writes while a transfer runs are dropped
  assign start = cmd.exec && (cmd.opcode == op_set_spi_data) && !busy;

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      spi_cs       <= 1'b0;
      busy         <= 1'b0;
      bit_timer    <= '0;
      flash_spi_si <= 1'b0;
    end else begin
      // control reg bit 7 is chip select, active high
      if (cmd.exec && cmd.opcode == op_set_spi_ctrl_reg) begin
        spi_cs <= cmd.param_0[7];
      end
      if (busy) begin
        bit_timer <= bit_timer + 1'b1;
        if (bit_timer == 8 * flash_bit_cycles - 1) begin
          busy <= 1'b0;
        end else if (bit_timer % flash_bit_cycles == flash_bit_cycles - 1) begin
          // next bit at the start of the following period
          flash_spi_si <= shift_reg[7];
        end
      end else if (start) begin
        busy         <= 1'b1;
        bit_timer    <= '0;
        flash_spi_si <= cmd.param_0[7];
      end
    end
  end

  // sample so where the flash clock rises
  always_ff @(posedge clk) begin
    if (start) begin
      shift_reg <= cmd.param_0;
    end else if (busy && (bit_timer % flash_bit_cycles == flash_bit_cycles / 2 - 1)) begin
      shift_reg <= {shift_reg[6:0], flash_spi_so};
    end
  end

  assign flash_data     = shift_reg;
  assign flash_spi_cs_n = ~spi_cs;
  // high in the second half of each bit period
  assign flash_spi_clk  = busy && (bit_timer % flash_bit_cycles >= flash_bit_cycles / 2);

endmodule

`default_nettype wire

// ==== trs_io_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module trs_io_top (
  input  logic             clk,
  input  logic             cass_out_sel_n,
  input  logic             spi_cs_n,
  input  logic             sck,
  input  logic             mosi,
  output logic             miso,
  input  logic [3:0]       conf,
  output logic             led_red,
  output logic             led_green,
  output logic             led_blue,
  output logic             error_led,
  output trs_io_pkg::rgb_t screen_color,
  output logic             flash_spi_cs_n,
  output logic             flash_spi_clk,
  output logic             flash_spi_si,
  input  logic             flash_spi_so
);
  import trs_io_pkg::*;

  byte_t rx_byte;
  logic  rx_valid;
  byte_t tx_byte;
  byte_t flash_data;
  logic  unknown_op;

  cmd_if cmd_bus ();

  // ESP command channel
  esp_spi_slave spi_slave_i (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .spi_cs_n       (spi_cs_n),
    .sck            (sck),
    .mosi           (mosi),
    .miso           (miso),
    .tx_byte        (tx_byte),
    .rx_byte        (rx_byte),
    .rx_valid       (rx_valid)
  );

  cmd_parser parser_i (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .rx_byte        (rx_byte),
    .rx_valid       (rx_valid),
    .cmd            (cmd_bus.source),
    .unknown_op     (unknown_op)
  );

  cmd_exec exec_i (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .cmd            (cmd_bus.sink),
    .unknown_op     (unknown_op),
    .conf           (conf),
    .flash_data     (flash_data),
    .tx_byte        (tx_byte),
    .led_red        (led_red),
    .led_green      (led_green),
    .led_blue       (led_blue),
    .error_led      (error_led),
    .screen_color   (screen_color)
  );

  // config flash port
  flash_spi_master flash_i (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .cmd            (cmd_bus.sink),
    .flash_spi_so   (flash_spi_so),
    .flash_data     (flash_data),
    .flash_spi_cs_n (flash_spi_cs_n),
    .flash_spi_clk  (flash_spi_clk),
    .flash_spi_si   (flash_spi_si)
  );

endmodule

`default_nettype wire

// ==== tb_trs_io_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_trs_io_top;
  import trs_io_pkg::*;

  // about 6500 clocks of traffic
  localparam int timeout_cycles = 20000;
  localparam int sck_half_clocks = 4;

  logic       clk;
  logic       cass_out_sel_n;
  logic       spi_cs_n;
  logic       sck;
  logic       mosi;
  logic       miso;
  logic [3:0] conf;
  logic       led_red;
  logic       led_green;
  logic       led_blue;
  logic       error_led;
  rgb_t       screen_color;
  logic       flash_spi_cs_n;
  logic       flash_spi_clk;
  logic       flash_spi_si;
  logic       flash_spi_so;

  byte_t      seq_bytes [$];
  logic       miso_bits [$];
  int         cycle_count = 0;
  int         flash_clk_pulses = 0;
  logic       flash_clk_prev = 1'b0;
  byte_t      flash_si_bits = '0;

  trs_io_top dut_i (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .spi_cs_n       (spi_cs_n),
    .sck            (sck),
    .mosi           (mosi),
    .miso           (miso),
    .conf           (conf),
    .led_red        (led_red),
    .led_green      (led_green),
    .led_blue       (led_blue),
    .error_led      (error_led),
    .screen_color   (screen_color),
    .flash_spi_cs_n (flash_spi_cs_n),
    .flash_spi_clk  (flash_spi_clk),
    .flash_spi_si   (flash_spi_si),
    .flash_spi_so   (flash_spi_so)
  );

  // flash loopback
  assign flash_spi_so = flash_spi_si;

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout: the tests did not finish within %0d clock cycles", timeout_cycles);
      $display("Testbench failed");
      $fatal(1);
    end
  end

  // rising edges of the flash clock, SI collected msb first
  always @(posedge clk) begin
    flash_clk_prev <= flash_spi_clk;
    if (flash_spi_clk && !flash_clk_prev) begin
      flash_clk_pulses <= flash_clk_pulses + 1;
      flash_si_bits    <= {flash_si_bits[6:0], flash_spi_si};
    end
  end

  // n rising edges, then the drive delay
  task automatic wait_clocks(input int n);
    repeat (n) @(posedge clk);
    #10;
  endtask

  task automatic check_value(input string name, input logic [23:0] actual,
                             input logic [23:0] expected);
    assert (actual === expected) else begin
      $display("error: time %0t, %s expected %0h, actual %0h", $time, name, expected, actual);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  // whole CS-low sequence, mode 0, one MISO sample per rising SCK
  task automatic send_sequence();
    byte_t b;
    miso_bits.delete();
    spi_cs_n = 1'b0;
    wait_clocks(sck_half_clocks);
    foreach (seq_bytes[n]) begin
      b = seq_bytes[n];
      for (int i = 7; i >= 0; i--) begin
        sck  = 1'b0;
        mosi = b[i];
        wait_clocks(sck_half_clocks);
        miso_bits.push_back(miso);
        sck = 1'b1;
        wait_clocks(sck_half_clocks);
      end
    end
    sck = 1'b0;
    wait_clocks(sck_half_clocks);
    spi_cs_n = 1'b1;
    wait_clocks(sck_half_clocks);
  endtask

  // reply to byte n: bits 7..1 during byte n+1, bit 0 on first edge of byte n+2
  function automatic byte_t response_of(input int n);
    byte_t r;
    for (int k = 0; k < 8; k++) begin
      r[7 - k] = miso_bits[8 * n + 9 + k];
    end
    return r;
  endfunction

  // read opcode followed by two get_cookie pad bytes
  task automatic read_response(input byte_t op, output byte_t resp);
    seq_bytes.delete();
    seq_bytes.push_back(op);
    seq_bytes.push_back(op_get_cookie);
    seq_bytes.push_back(op_get_cookie);
    send_sequence();
    resp = response_of(0);
  endtask

  task automatic write_one(input byte_t op, input byte_t data);
    seq_bytes.delete();
    seq_bytes.push_back(op);
    seq_bytes.push_back(data);
    send_sequence();
  endtask

  initial begin
    byte_t resp;
    byte_t data;
    byte_t red;
    byte_t green;
    byte_t blue;
    int    pulses_before;

    void'($urandom(32'h7e32_239c));
    cass_out_sel_n = 1'b0;
    spi_cs_n       = 1'b1;
    sck            = 1'b0;
    mosi           = 1'b0;
    conf           = 4'h0;
    wait_clocks(10);
    cass_out_sel_n = 1'b1;
    wait_clocks(2);

    // reset values
    check_value("led_red", led_red, 0);
    check_value("led_green", led_green, 0);
    check_value("led_blue", led_blue, 0);
    check_value("error_led", error_led, 0);
    check_value("screen_color", screen_color, 24'hFFFFFF);
    check_value("flash_spi_cs_n", flash_spi_cs_n, 1);
    check_value("flash_spi_clk", flash_spi_clk, 0);
    check_value("miso", miso, 0);

    // reads, conf[3] alternates low and high
    for (int i = 0; i < 4; i++) begin
      conf = {i[0], 3'($urandom)};
      read_response(op_get_cookie, resp);
      check_value("get_cookie response", resp, 8'hAF);
      read_response(op_get_version, resp);
      check_value("get_version response", resp, 8'h03);
      read_response(op_get_mode, resp);
      check_value("get_mode response", resp, conf[3] ? 8'h03 : 8'h0B);
      read_response(op_get_config, resp);
      check_value("get_config response", resp, {4'h0, ~conf});
    end

    for (int i = 0; i < 3; i++) begin
      // middle write is the complement so every LED sees both levels
      data = (i == 1) ? ~data : 8'($urandom);
      write_one(op_set_led, data);
      check_value("led_red", led_red, data[0]);
      check_value("led_green", led_green, data[1]);
      check_value("led_blue", led_blue, data[2]);
    end

    for (int i = 0; i < 2; i++) begin
      red   = 8'($urandom);
      green = 8'($urandom);
      blue  = 8'($urandom);
      seq_bytes.delete();
      seq_bytes.push_back(op_set_screen_color);
      seq_bytes.push_back(red);
      seq_bytes.push_back(green);
      seq_bytes.push_back(blue);
      send_sequence();
      check_value("screen_color", screen_color, {red, green, blue});
    end

    // flash chip select is bit 7 of the control register
    write_one(op_set_spi_ctrl_reg, 8'h80 | 8'($urandom));
    check_value("flash_spi_cs_n", flash_spi_cs_n, 0);
    write_one(op_set_spi_ctrl_reg, 8'h7F & 8'($urandom));
    check_value("flash_spi_cs_n", flash_spi_cs_n, 1);
    write_one(op_set_spi_ctrl_reg, 8'h80);
    check_value("flash_spi_cs_n", flash_spi_cs_n, 0);

    for (int i = 0; i < 2; i++) begin
      data          = 8'($urandom);
      pulses_before = flash_clk_pulses;
      write_one(op_set_spi_data, data);
      // a transfer is 8 bits of 16 clocks
      wait_clocks(8 * 16 + 16);
      check_value("flash_spi_clk pulse count", flash_clk_pulses - pulses_before, 8);
      check_value("flash_spi_si serial byte", flash_si_bits, data);
      read_response(op_get_spi_data, resp);
      check_value("get_spi_data response", resp, data);
    end

    // unknown opcode, then normal commands again
    seq_bytes.delete();
    seq_bytes.push_back(8'd99);
    send_sequence();
    check_value("error_led", error_led, 1);
    data = 8'($urandom);
    write_one(op_set_led, data);
    check_value("led_red", led_red, data[0]);
    check_value("led_green", led_green, data[1]);
    check_value("led_blue", led_blue, data[2]);
    read_response(op_get_cookie, resp);
    check_value("get_cookie response", resp, 8'hAF);
    check_value("error_led", error_led, 1);

    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
trs_io_pkg.sv
cmd_if.sv
esp_spi_slave.sv
cmd_parser.sv
cmd_exec.sv
flash_spi_master.sv
trs_io_top.sv
tb_trs_io_top.sv

// ==== run_sim.sh ====
#!/bin/bash
# build the testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --assert -Wno-fatal --top-module tb_trs_io_top -f build.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Testbench passed$" "$log"; then
  echo "simulation result: PASS"
  exit 0
fi
echo "simulation result: FAIL"
exit 1
